// File: design/rx_async_pkg.sv
// RX async sideband shared types
`default_nettype none

package rx_async_pkg;

	// Field widths
	parameter int WA_BOUNDARY_W = 5;
	parameter int A1A2_FLAG_W   = 4;
	parameter int EYE_MON_W     = 6;
	parameter int STRETCH_NUM_W = 3;
	parameter int STRETCH_DEPTH = 2 ** STRETCH_NUM_W;

	// Rate-match FIFO and PRBS event flags
	typedef struct packed {
		logic empty_rmf;
		logic full_rmf;
		logic prbs_err;
	} rmf_flags_t;

	// PCS status levels, first field is the MSB
	typedef struct packed {
		logic                     krfec_blk_lock;
		logic [1:0]               krfec_diag_status;
		logic                     krfec_frame;
		logic                     crc32_err;
		logic                     frame_lock;
		logic                     hi_ber;
		logic [A1A2_FLAG_W-1:0]   a1a2_k1k2_flag;
		logic                     signal_detect;
		logic [WA_BOUNDARY_W-1:0] wa_boundary;
		logic                     adapt_done;
		logic [1:0]               pcie_sw_done;
		logic                     rx_detect_valid;
		logic                     signal_ok;
		logic                     fifo_empty;
		logic                     fifo_full;
	} pcs_status_t;

	// Slow status word as seen by the fabric
	typedef struct packed {
		pcs_status_t pcs;
		rmf_flags_t  flags;
	} ssr_status_t;

	// Fast status word
	typedef struct packed {
		logic prbs_done;
		logic prbs_err;
	} fsr_status_t;

	// Slow control word from the fabric
	typedef struct packed {
		logic                 krfec_clr_errblk_cnt;
		logic                 clr_ber_count;
		logic                 a1a2_size;
		logic                 bitloc_rev_en;
		logic                 byte_rev_en;
		logic [2:0]           eidleinfersel;
		logic                 encdt;
		logic                 ltr;
		logic                 adapt_start;
		logic                 early_eios;
		logic [EYE_MON_W-1:0] eye_monitor;
		logic                 ltd_b;
		logic [1:0]           pcie_switch;
		logic                 ppm_lock;
		logic                 rs_lpbk_b;
		logic                 polinv_rx;
		logic                 syncsm_en;
		logic                 fifo_latency_adj_en;
		logic                 wr_align_clr;
		logic                 fabric_rx_dll_lock;
		logic                 pld_rx_dll_lock_req;
		logic                 fabric_rx_transfer_en;
		logic                 dcd_cal_req;
		logic [1:0]           spare;
	} ssr_ctrl_t;

	// Fast control word from the fabric
	typedef struct packed {
		logic bitslip;
		logic rxclkslip;
		logic prbs_err_clr;
	} fsr_ctrl_t;

endpackage

`default_nettype wire

// File: design/rx_flag_conditioner.sv
// RMF and PRBS flag sync and stretch
`timescale 1ns/1ns
`default_nettype none

module rx_flag_conditioner (
	input  logic                                   rx_osc_clk,
	input  logic                                   rst,
	input  rx_async_pkg::rmf_flags_t               raw_flags,
	input  logic                                   stretch_enable,
	input  logic [rx_async_pkg::STRETCH_NUM_W-1:0] stretch_num_stages,
	output rx_async_pkg::rmf_flags_t               cond_flags
);

	localparam int FLAG_W = $bits(rx_async_pkg::rmf_flags_t);
	localparam int DEPTH  = rx_async_pkg::STRETCH_DEPTH;

	logic [FLAG_W-1:0]            sync_q1;
	logic [FLAG_W-1:0]            sync_q2;
	logic [DEPTH-1:0][FLAG_W-1:0] flag_hist;
	logic [FLAG_W-1:0]            stretched;

	// Two-flop synchronizer, flags are async to rx_osc_clk
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= raw_flags;
			sync_q2 <= sync_q1;
		end
	end

	// History shift register, entry 0 is the newest
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			flag_hist <= '0;
		end else begin
			flag_hist <= {flag_hist[DEPTH-2:0], sync_q2};
		end
	end

	// OR of the newest stretch_num_stages+1 entries
	always_comb begin
		stretched = '0;
		for (int k = 0; k < DEPTH; k++) begin
			if (k <= int'(stretch_num_stages)) begin
				stretched = stretched | flag_hist[k];
			end
		end
	end

	// Bypass passes the raw flags straight through
	assign cond_flags = stretch_enable ? rx_async_pkg::rmf_flags_t'(stretched) : raw_flags;

	a_bypass_raw: assert property (
		@(posedge rx_osc_clk) !stretch_enable |-> cond_flags == raw_flags
	) else $error("cond_flags differs from raw_flags in bypass");

	// A flag seen three edges ago must still show when stretching
	a_stretch_min: assert property (
		@(posedge rx_osc_clk) disable iff (rst)
		stretch_enable && $stable(stretch_enable) ##0 $past(raw_flags.prbs_err, 3)
			&& !$past(rst, 3) && !$past(rst, 2) && !$past(rst, 1)
			|-> cond_flags.prbs_err
	) else $error("stretched prbs_err dropped");

endmodule

`default_nettype wire

// File: design/rx_status_capture.sv
// Slow and fast status capture
`timescale 1ns/1ns
`default_nettype none

module rx_status_capture #(
	parameter bit SIGDET_RST_VAL  = 1'b0,
	parameter bit CRC_ERR_RST_VAL = 1'b0
) (
	input  logic                      rx_osc_clk,
	input  logic                      rst,
	input  rx_async_pkg::pcs_status_t pcs_status,
	input  rx_async_pkg::rmf_flags_t  cond_flags,
	input  logic                      prbs_done,
	input  logic                      hssi_ssr_load,
	input  logic                      hssi_fsr_load,
	output rx_async_pkg::ssr_status_t ssr_status,
	output rx_async_pkg::fsr_status_t fsr_status
);

	rx_async_pkg::ssr_status_t ssr_next;
	rx_async_pkg::fsr_status_t fsr_next;

	// Words presented for capture
	always_comb begin
		ssr_next.pcs   = pcs_status;
		ssr_next.flags = cond_flags;
		fsr_next.prbs_done = prbs_done;
		fsr_next.prbs_err  = cond_flags.prbs_err;
	end

	// Slow status word
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			ssr_status <= '0;
			ssr_status.pcs.signal_detect <= SIGDET_RST_VAL;
			ssr_status.pcs.crc32_err     <= CRC_ERR_RST_VAL;
		end else if (hssi_ssr_load) begin
			ssr_status <= ssr_next;
		end
	end

	// Fast status word
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			fsr_status <= '0;
		end else if (hssi_fsr_load) begin
			fsr_status <= fsr_next;
		end
	end

	a_ssr_hold: assert property (
		@(posedge rx_osc_clk) disable iff (rst)
		!hssi_ssr_load |=> $stable(ssr_status)
	) else $error("ssr_status changed without a load");

	a_fsr_hold: assert property (
		@(posedge rx_osc_clk) disable iff (rst)
		!hssi_fsr_load |=> $stable(fsr_status)
	) else $error("fsr_status changed without a load");

endmodule

`default_nettype wire

// File: design/rx_control_update.sv
// Fabric control update and DFT override
`timescale 1ns/1ns
`default_nettype none

module rx_control_update #(
	parameter bit LTR_RST_VAL   = 1'b0,
	parameter bit LTD_B_RST_VAL = 1'b0
) (
	input  logic                    rx_osc_clk,
	input  logic                    rst,
	input  rx_async_pkg::ssr_ctrl_t fabric_ssr_data,
	input  logic                    fabric_ssr_load,
	input  rx_async_pkg::fsr_ctrl_t fabric_fsr_data,
	input  logic                    fabric_fsr_load,
	input  logic                    dft_adpt_rst,
	output rx_async_pkg::ssr_ctrl_t pcs_ctrl,
	output rx_async_pkg::fsr_ctrl_t pcs_fast_ctrl,
	output rx_async_pkg::ssr_ctrl_t ssr_parity_copy,
	output rx_async_pkg::fsr_ctrl_t fsr_parity_copy
);

	rx_async_pkg::ssr_ctrl_t ssr_q;
	rx_async_pkg::fsr_ctrl_t fsr_q;

	// Slow control register
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			ssr_q       <= '0;
			ssr_q.ltr   <= LTR_RST_VAL;
			ssr_q.ltd_b <= LTD_B_RST_VAL;
		end else if (fabric_ssr_load) begin
			ssr_q <= fabric_ssr_data;
		end
	end

	// Fast control register
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			fsr_q <= '0;
		end else if (fabric_fsr_load) begin
			fsr_q <= fabric_fsr_data;
		end
	end

	// DFT reset holds the PMA in lock-to-reference
	always_comb begin
		pcs_ctrl = ssr_q;
		if (dft_adpt_rst) begin
			pcs_ctrl.ltr   = 1'b1;
			pcs_ctrl.ltd_b = 1'b1;
		end
	end

	assign pcs_fast_ctrl = fsr_q;

	// Parity checker sees the latched words, not the override
	assign ssr_parity_copy = ssr_q;
	assign fsr_parity_copy = fsr_q;

	a_dft_override: assert property (
		@(posedge rx_osc_clk)
		dft_adpt_rst |-> pcs_ctrl.ltr && pcs_ctrl.ltd_b
	) else $error("DFT override not applied to ltr/ltd_b");

	// Loaded words reach the outputs one cycle later
	a_ssr_load: assert property (
		@(posedge rx_osc_clk) disable iff (rst)
		fabric_ssr_load |=> ssr_parity_copy == $past(fabric_ssr_data)
	) else $error("ssr control not loaded");

	a_fsr_load: assert property (
		@(posedge rx_osc_clk) disable iff (rst)
		fabric_fsr_load |=> pcs_fast_ctrl == $past(fabric_fsr_data)
	) else $error("fsr control not loaded");

endmodule

`default_nettype wire

// File: design/rx_async_adapter.sv
// RX async sideband adapter
// Flag conditioning, status capture and control update
`timescale 1ns/1ns
`default_nettype none

module rx_async_adapter #(
	parameter bit SIGDET_RST_VAL  = 1'b0,
	parameter bit CRC_ERR_RST_VAL = 1'b0,
	parameter bit LTR_RST_VAL     = 1'b0,
	parameter bit LTD_B_RST_VAL   = 1'b0
) (
	input  logic                                   rx_osc_clk,
	input  logic                                   rst,

	// PCS status and event flags
	input  rx_async_pkg::pcs_status_t              pcs_status,
	input  rx_async_pkg::rmf_flags_t               raw_flags,
	input  logic                                   prbs_done,

	// Static configuration
	input  logic                                   stretch_enable,
	input  logic [rx_async_pkg::STRETCH_NUM_W-1:0] stretch_num_stages,

	// Fabric control words
	input  rx_async_pkg::ssr_ctrl_t                fabric_ssr_data,
	input  logic                                   fabric_ssr_load,
	input  rx_async_pkg::fsr_ctrl_t                fabric_fsr_data,
	input  logic                                   fabric_fsr_load,

	// Status capture strobes
	input  logic                                   hssi_ssr_load,
	input  logic                                   hssi_fsr_load,

	input  logic                                   dft_adpt_rst,

	output rx_async_pkg::ssr_status_t              ssr_status,
	output rx_async_pkg::fsr_status_t              fsr_status,
	output rx_async_pkg::ssr_ctrl_t                pcs_ctrl,
	output rx_async_pkg::fsr_ctrl_t                pcs_fast_ctrl,
	output rx_async_pkg::ssr_ctrl_t                ssr_parity_copy,
	output rx_async_pkg::fsr_ctrl_t                fsr_parity_copy
);

	rx_async_pkg::rmf_flags_t cond_flags;

	rx_flag_conditioner rx_flag_conditioner_i (
		.rx_osc_clk         (rx_osc_clk),
		.rst                (rst),
		.raw_flags          (raw_flags),
		.stretch_enable     (stretch_enable),
		.stretch_num_stages (stretch_num_stages),
		.cond_flags         (cond_flags)
	);

	rx_status_capture #(
		.SIGDET_RST_VAL  (SIGDET_RST_VAL),
		.CRC_ERR_RST_VAL (CRC_ERR_RST_VAL)
	) rx_status_capture_i (
		.rx_osc_clk    (rx_osc_clk),
		.rst           (rst),
		.pcs_status    (pcs_status),
		.cond_flags    (cond_flags),
		.prbs_done     (prbs_done),
		.hssi_ssr_load (hssi_ssr_load),
		.hssi_fsr_load (hssi_fsr_load),
		.ssr_status    (ssr_status),
		.fsr_status    (fsr_status)
	);

	rx_control_update #(
		.LTR_RST_VAL   (LTR_RST_VAL),
		.LTD_B_RST_VAL (LTD_B_RST_VAL)
	) rx_control_update_i (
		.rx_osc_clk      (rx_osc_clk),
		.rst             (rst),
		.fabric_ssr_data (fabric_ssr_data),
		.fabric_ssr_load (fabric_ssr_load),
		.fabric_fsr_data (fabric_fsr_data),
		.fabric_fsr_load (fabric_fsr_load),
		.dft_adpt_rst    (dft_adpt_rst),
		.pcs_ctrl        (pcs_ctrl),
		.pcs_fast_ctrl   (pcs_fast_ctrl),
		.ssr_parity_copy (ssr_parity_copy),
		.fsr_parity_copy (fsr_parity_copy)
	);

endmodule

`default_nettype wire

// File: bench/rx_async_tb.sv
// RX async sideband adapter testbench
`timescale 1ns/1ns
`default_nettype none

module rx_async_tb;

	localparam int DEPTH      = rx_async_pkg::STRETCH_DEPTH;
	localparam int HIST_D     = DEPTH + 2;
	localparam int WAIT_LIMIT = 24;

	logic                                   rx_osc_clk;
	logic                                   rst;
	rx_async_pkg::pcs_status_t              pcs_status;
	rx_async_pkg::rmf_flags_t               raw_flags;
	logic                                   prbs_done;
	logic                                   stretch_enable;
	logic [rx_async_pkg::STRETCH_NUM_W-1:0] stretch_num_stages;
	rx_async_pkg::ssr_ctrl_t                fabric_ssr_data;
	logic                                   fabric_ssr_load;
	rx_async_pkg::fsr_ctrl_t                fabric_fsr_data;
	logic                                   fabric_fsr_load;
	logic                                   hssi_ssr_load;
	logic                                   hssi_fsr_load;
	logic                                   dft_adpt_rst;
	rx_async_pkg::ssr_status_t              ssr_status;
	rx_async_pkg::fsr_status_t              fsr_status;
	rx_async_pkg::ssr_ctrl_t                pcs_ctrl;
	rx_async_pkg::fsr_ctrl_t                pcs_fast_ctrl;
	rx_async_pkg::ssr_ctrl_t                ssr_parity_copy;
	rx_async_pkg::fsr_ctrl_t                fsr_parity_copy;

	// Reference model state
	logic [HIST_D-1:0][2:0]    raw_hist;
	logic [2:0]                exp_stretched;
	rx_async_pkg::rmf_flags_t  exp_cond;
	rx_async_pkg::ssr_status_t ssr_shadow;
	rx_async_pkg::fsr_status_t fsr_shadow;
	rx_async_pkg::ssr_ctrl_t   ssr_ctrl_shadow;
	rx_async_pkg::fsr_ctrl_t   fsr_ctrl_shadow;
	rx_async_pkg::ssr_ctrl_t   exp_pcs_ctrl;
	logic [31:0]               rng_state;

	rx_async_adapter #(
		.SIGDET_RST_VAL (1'b1),
		.LTR_RST_VAL    (1'b1)
	) rx_async_adapter_i (
		.rx_osc_clk         (rx_osc_clk),
		.rst                (rst),
		.pcs_status         (pcs_status),
		.raw_flags          (raw_flags),
		.prbs_done          (prbs_done),
		.stretch_enable     (stretch_enable),
		.stretch_num_stages (stretch_num_stages),
		.fabric_ssr_data    (fabric_ssr_data),
		.fabric_ssr_load    (fabric_ssr_load),
		.fabric_fsr_data    (fabric_fsr_data),
		.fabric_fsr_load    (fabric_fsr_load),
		.hssi_ssr_load      (hssi_ssr_load),
		.hssi_fsr_load      (hssi_fsr_load),
		.dft_adpt_rst       (dft_adpt_rst),
		.ssr_status         (ssr_status),
		.fsr_status         (fsr_status),
		.pcs_ctrl           (pcs_ctrl),
		.pcs_fast_ctrl      (pcs_fast_ctrl),
		.ssr_parity_copy    (ssr_parity_copy),
		.fsr_parity_copy    (fsr_parity_copy)
	);

	initial begin
		rx_osc_clk = 1'b0;
		forever #2 rx_osc_clk = ~rx_osc_clk;
	end

	function automatic rx_async_pkg::ssr_status_t status_reset_value();
		rx_async_pkg::ssr_status_t v;
		v = '0;
		v.pcs.signal_detect = 1'b1;
		return v;
	endfunction

	function automatic rx_async_pkg::ssr_ctrl_t ctrl_reset_value();
		rx_async_pkg::ssr_ctrl_t v;
		v = '0;
		v.ltr = 1'b1;
		return v;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic fail_run(input string why);
		$display("Timeout: %s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// Raw flags seen at each edge, entry 0 is the newest
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			raw_hist <= '0;
		end else begin
			raw_hist <= {raw_hist[HIST_D-2:0], raw_flags};
		end
	end

	// Two sync stages, then stretch_num_stages+1 history entries
	always_comb begin
		exp_stretched = '0;
		for (int k = 0; k < DEPTH; k++) begin
			if (k <= int'(stretch_num_stages)) begin
				exp_stretched = exp_stretched | raw_hist[k + 2];
			end
		end
		exp_cond = stretch_enable ? exp_stretched : raw_flags;
		exp_pcs_ctrl = ssr_ctrl_shadow;
		if (dft_adpt_rst) begin
			exp_pcs_ctrl.ltr   = 1'b1;
			exp_pcs_ctrl.ltd_b = 1'b1;
		end
	end

	// Shadow copies of every loaded word
	always_ff @(posedge rx_osc_clk) begin
		if (rst) begin
			ssr_shadow      <= status_reset_value();
			fsr_shadow      <= '0;
			ssr_ctrl_shadow <= ctrl_reset_value();
			fsr_ctrl_shadow <= '0;
		end else begin
			if (hssi_ssr_load) ssr_shadow <= {pcs_status, exp_cond};
			if (hssi_fsr_load) fsr_shadow <= {prbs_done, exp_cond.prbs_err};
			if (fabric_ssr_load) ssr_ctrl_shadow <= fabric_ssr_data;
			if (fabric_fsr_load) fsr_ctrl_shadow <= fabric_fsr_data;
		end
	end

	// Values right after reset release
	a_rst_ssr: assert property (@(posedge rx_osc_clk)
		$fell(rst) |-> ssr_status == status_reset_value())
		else report_mismatch("ssr_status", 32'($sampled(ssr_status)), 32'(status_reset_value()));
	a_rst_fsr: assert property (@(posedge rx_osc_clk) $fell(rst) |-> fsr_status == '0)
		else report_mismatch("fsr_status", 32'($sampled(fsr_status)), 32'h0);
	a_rst_ctrl: assert property (@(posedge rx_osc_clk)
		$fell(rst) |-> pcs_ctrl == ctrl_reset_value())
		else report_mismatch("pcs_ctrl", 32'($sampled(pcs_ctrl)), 32'(ctrl_reset_value()));
	a_rst_fast: assert property (@(posedge rx_osc_clk) $fell(rst) |-> pcs_fast_ctrl == '0)
		else report_mismatch("pcs_fast_ctrl", 32'($sampled(pcs_fast_ctrl)), 32'h0);

	// Captured and latched words against the shadows, every cycle
	a_ssr_status: assert property (@(posedge rx_osc_clk) disable iff (rst)
		ssr_status == ssr_shadow)
		else report_mismatch("ssr_status", 32'($sampled(ssr_status)), 32'($sampled(ssr_shadow)));
	a_fsr_status: assert property (@(posedge rx_osc_clk) disable iff (rst)
		fsr_status == fsr_shadow)
		else report_mismatch("fsr_status", 32'($sampled(fsr_status)), 32'($sampled(fsr_shadow)));
	a_pcs_ctrl: assert property (@(posedge rx_osc_clk) disable iff (rst)
		pcs_ctrl == exp_pcs_ctrl)
		else report_mismatch("pcs_ctrl", 32'($sampled(pcs_ctrl)), 32'($sampled(exp_pcs_ctrl)));
	a_pcs_fast: assert property (@(posedge rx_osc_clk) disable iff (rst)
		pcs_fast_ctrl == fsr_ctrl_shadow)
		else report_mismatch("pcs_fast_ctrl", 32'($sampled(pcs_fast_ctrl)),
			32'($sampled(fsr_ctrl_shadow)));
	a_ssr_parity: assert property (@(posedge rx_osc_clk) disable iff (rst)
		ssr_parity_copy == ssr_ctrl_shadow)
		else report_mismatch("ssr_parity_copy", 32'($sampled(ssr_parity_copy)),
			32'($sampled(ssr_ctrl_shadow)));
	a_fsr_parity: assert property (@(posedge rx_osc_clk) disable iff (rst)
		fsr_parity_copy == fsr_ctrl_shadow)
		else report_mismatch("fsr_parity_copy", 32'($sampled(fsr_parity_copy)),
			32'($sampled(fsr_ctrl_shadow)));

	task automatic step();
		@(posedge rx_osc_clk);
		#1;
	endtask

	// Sparse flags, loads and DFT about a quarter of the time
	task automatic drive_random();
		logic [31:0] r;
		r = next_rand();
		pcs_status = r[$bits(rx_async_pkg::pcs_status_t)-1:0];
		fabric_ssr_data = next_rand();
		r = next_rand();
		raw_flags = r[2:0] & r[22:20] & r[25:23];
		prbs_done = r[3];
		fabric_fsr_data = r[6:4];
		hssi_ssr_load = (r[9:8] == 2'b00);
		hssi_fsr_load = (r[11:10] == 2'b00);
		fabric_ssr_load = (r[13:12] == 2'b00);
		fabric_fsr_load = (r[15:14] == 2'b00);
		dft_adpt_rst = (r[17:16] == 2'b00);
	endtask

	// One-cycle pulse on one flag, captured on every edge until it clears
	task automatic pulse_and_capture(input int flag_idx);
		logic [2:0]  mask;
		logic [31:0] r;
		int          wait_cycles;
		mask = 3'b001 << flag_idx;
		r = next_rand();
		stretch_num_stages = r[rx_async_pkg::STRETCH_NUM_W-1:0];
		raw_flags = '0;
		hssi_ssr_load = 1'b0;
		hssi_fsr_load = 1'b0;
		repeat (HIST_D + 1) step();
		raw_flags = mask;
		hssi_ssr_load = 1'b1;
		hssi_fsr_load = 1'b1;
		step();
		raw_flags = '0;
		wait_cycles = 0;
		while ((3'(ssr_status.flags) & mask) == 3'b000) begin
			if (wait_cycles == WAIT_LIMIT) fail_run("stretched flag never reached ssr_status");
			step();
			wait_cycles++;
		end
		wait_cycles = 0;
		while ((3'(ssr_status.flags) & mask) != 3'b000) begin
			if (wait_cycles == WAIT_LIMIT) fail_run("stretched flag never cleared");
			step();
			wait_cycles++;
		end
		hssi_ssr_load = 1'b0;
		hssi_fsr_load = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		rng_state = 32'h4460_32ab;
		rst = 1'b1;
		pcs_status = '0;
		raw_flags = '0;
		prbs_done = 1'b0;
		stretch_enable = 1'b0;
		stretch_num_stages = '0;
		fabric_ssr_data = '0;
		fabric_ssr_load = 1'b0;
		fabric_fsr_data = '0;
		fabric_fsr_load = 1'b0;
		hssi_ssr_load = 1'b0;
		hssi_fsr_load = 1'b0;
		dft_adpt_rst = 1'b0;
		repeat (16) @(posedge rx_osc_clk);
		#1;
		rst = 1'b0;
		step();

		// Flags in bypass
		repeat (300) begin
			drive_random();
			step();
		end

		// Stretching with a new stage count per segment
		stretch_enable = 1'b1;
		repeat (8) begin
			r = next_rand();
			stretch_num_stages = r[rx_async_pkg::STRETCH_NUM_W-1:0];
			repeat (60) begin
				drive_random();
				step();
			end
		end

		dft_adpt_rst = 1'b0;
		fabric_ssr_load = 1'b0;
		fabric_fsr_load = 1'b0;
		for (int i = 0; i < 3; i++) begin
			pulse_and_capture(i);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
design/rx_async_pkg.sv
design/rx_flag_conditioner.sv
design/rx_status_capture.sv
design/rx_control_update.sv
design/rx_async_adapter.sv
bench/rx_async_tb.sv
